// ==== mera_pd.f ====
hw/mera_isa_pkg.sv
hw/mera_ctl_pkg.sv
hw/p_d.sv
hw/cpu_ctl.sv
hw/alu_flags.sv
hw/regfile.sv
hw/mera_exec.sv
tb/mera_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mera_exec testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f mera_pd.f \
	--top-module mera_exec_tb -o mera_exec_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/mera_exec_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== tb/mera_exec_tb.sv ====
`timescale 1ns/1ps
// ****************************************
// Testbench for mera_exec: clock, reset,
// reference model, directed tests, checks
// ****************************************
module mera_exec_tb import mera_isa_pkg::*; ();

	localparam logic [0:WORD_W-1] IC_START = 16'h0100;

	logic              clk;
	logic              rst_n;
	logic [0:WORD_W-1] w;
	logic              w_stb;
	logic [0:FLD_W-1]  panel_sel;
	logic              ekc;
	logic              xi;
	logic              nef;
	logic [0:WORD_W-1] ic;
	logic [0:WORD_W-1] panel_data;
	logic [0:WORD_W-1] mr [0:7];        // Model R0..R7
	logic [0:WORD_W-1] mic;             // Model IC
	logic [31:0]       rng;             // Random state

	mera_exec #(.IC_RESET(IC_START)) dut0 (
		.clk(clk), .rst_n(rst_n), .w(w), .w_stb(w_stb), .panel_sel(panel_sel),
		.ekc(ekc), .xi(xi), .nef(nef), .ic(ic), .panel_data(panel_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;              // 8 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	task automatic next_word(output logic [0:WORD_W-1] v);
		rng = xorshift(rng);
		v = rng[15:0];
	endtask

	// Instruction word: opcode, D=0, A, B=0, C
	function automatic logic [0:WORD_W-1] encode(input opcode_t op, input logic [0:2] a,
		input logic [0:2] c);
		logic [0:5] opc;
		logic [0:2] af;
		case (op)
			OP_LW:   opc = 6'o20;
			OP_AW:   opc = 6'o40;
			OP_AC:   opc = 6'o41;
			OP_SW:   opc = 6'o42;
			OP_CW:   opc = 6'o43;
			OP_OR:   opc = 6'o44;
			OP_NR:   opc = 6'o46;
			OP_ER:   opc = 6'o50;
			OP_XR:   opc = 6'o52;
			default: opc = 6'o74;           // Group J
		endcase
		case (op)
			OP_UJ:   af = 3'd2;
			OP_JZ:   af = 3'd4;
			OP_JM:   af = 3'd5;
			OP_JN:   af = 3'd6;
			default: af = a;
		endcase
		return {opc, 1'b0, af, 3'b000, c};
	endfunction

	task automatic check_word(input string name, input logic [0:WORD_W-1] expected,
		input logic [0:WORD_W-1] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %b actual %b", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	// Reference model, updates mr and mic from pre-instruction state
	task automatic model_exec(input opcode_t op, input logic [0:2] a, input logic [0:2] c,
		input logic [0:WORD_W-1] argw, output logic exp_xi, output logic exp_nef);
		logic [0:WORD_W-1] argv;
		logic [0:WORD_W-1] ra;
		logic [0:WORD_W-1] y;
		logic [16:0]       s;
		logic              v;
		logic              cy;
		argv = (c == 3'd0) ? argw : mr[c];
		ra = mr[a];
		v = mr[0][R0_V];
		cy = mr[0][R0_C];
		y = ra;
		exp_xi = 1'b0;
		exp_nef = 1'b0;
		mic = mic + ((c == 3'd0) ? 16'd2 : 16'd1);   // One per word sent
		case (op)
			OP_LW: y = argv;
			OP_AW, OP_AC: begin
				s = {1'b0, ra} + {1'b0, argv} + {16'd0, (op == OP_AC) && cy};
				y = s[15:0];
				v = (ra[0] == argv[0]) && (y[0] != ra[0]);
				cy = s[16];
			end
			OP_SW, OP_CW: begin
				s = {1'b0, ra} + {1'b0, ~argv} + 17'd1;
				y = s[15:0];
				v = (ra[0] != argv[0]) && (y[0] != ra[0]);   // Signs differ, result flips
				cy = s[16];
			end
			OP_OR: y = ra | argv;
			OP_NR: y = ra & argv;
			OP_ER: y = ra & ~argv;
			OP_XR: y = ra ^ argv;
			OP_UJ: mic = argv;
			OP_JZ, OP_JM, OP_JN: begin
				if ((op == OP_JZ && mr[0][R0_Z]) || (op == OP_JM && mr[0][R0_M]) ||
					(op == OP_JN && !mr[0][R0_Z]))
					mic = argv;
				else
					exp_nef = 1'b1;
			end
			default: exp_xi = 1'b1;
		endcase
		if (op inside {OP_AW, OP_AC, OP_SW, OP_CW, OP_OR, OP_NR, OP_ER, OP_XR})
			mr[0] = {y == 16'd0, y[0], v, cy, 12'h000};
		if (op inside {OP_LW, OP_AW, OP_AC, OP_SW, OP_OR, OP_NR, OP_ER, OP_XR})
			mr[a] = y;                          // Beats the flag write for A=0
	endtask

	task automatic check_state(input string name);
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			panel_sel = 3'(i);
			#1;
			check_word($sformatf("%s R%0d", name, i), mr[i], panel_data);
		end
		check_word({name, " IC"}, mic, ic);
	endtask

	task automatic exec_instr(input string name, input opcode_t op,
		input logic [0:WORD_W-1] instr, input logic [0:WORD_W-1] argw);
		logic exp_xi;
		logic exp_nef;
		int   n;
		model_exec(op, instr[7:9], instr[13:15], argw, exp_xi, exp_nef);
		@(negedge clk);
		w = instr;
		w_stb = 1'b1;
		@(negedge clk);
		w_stb = 1'b0;
		if (instr[13:15] == 3'd0) begin
			w = argw;                           // Argument word
			w_stb = 1'b1;
			@(negedge clk);
			w_stb = 1'b0;
		end
		n = 0;
		while (!ekc && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (!ekc) begin
			$display("Timeout: no cycle end strobe for %s", name);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
		check_bit({name, " xi"}, exp_xi, xi);
		check_bit({name, " nef"}, exp_nef, nef);
		check_state(name);
	endtask

	// Random A, C and argument, register A preloaded with a random word
	task automatic random_alu(input opcode_t op, input int count);
		logic [0:WORD_W-1] v;
		logic [0:WORD_W-1] f;
		for (int k = 0; k < count; k++) begin
			next_word(v);
			next_word(f);
			exec_instr($sformatf("%s setup %0d", op.name(), k), OP_LW,
				encode(OP_LW, f[0:2], 3'd0), v);
			next_word(v);
			exec_instr($sformatf("%s %0d", op.name(), k), op, encode(op, f[0:2], f[3:5]), v);
		end
	endtask

	task automatic jumps();
		exec_instr("set Z", OP_LW, encode(OP_LW, 3'd0, 3'd0), 16'h8000);
		exec_instr("jz taken", OP_JZ, encode(OP_JZ, 3'd0, 3'd0), 16'h0200);
		exec_instr("jn skipped", OP_JN, encode(OP_JN, 3'd0, 3'd0), 16'h0300);
		exec_instr("jm skipped", OP_JM, encode(OP_JM, 3'd0, 3'd2), 16'h0000);
		exec_instr("set M", OP_LW, encode(OP_LW, 3'd0, 3'd0), 16'h4000);
		exec_instr("jm taken", OP_JM, encode(OP_JM, 3'd0, 3'd2), 16'h0000);   // Target R2
		exec_instr("jz skipped", OP_JZ, encode(OP_JZ, 3'd0, 3'd3), 16'h0000);
		exec_instr("jn taken", OP_JN, encode(OP_JN, 3'd0, 3'd0), 16'h0440);
		exec_instr("uj", OP_UJ, encode(OP_UJ, 3'd0, 3'd5), 16'h0000);
	endtask

	initial begin
		rst_n = 1'b0;
		w = '0;
		w_stb = 1'b0;
		panel_sel = '0;
		rng = 32'h2611;
		mic = IC_START;
		for (int i = 0; i < 8; i++) begin
			mr[i] = '0;
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		check_bit("reset ekc", 1'b0, ekc);
		check_bit("reset xi", 1'b0, xi);
		check_bit("reset nef", 1'b0, nef);
		check_state("reset");
		exec_instr("lw next", OP_LW, encode(OP_LW, 3'd3, 3'd0), 16'hbeef);
		exec_instr("lw reg", OP_LW, encode(OP_LW, 3'd5, 3'd3), 16'h0000);
		random_alu(OP_LW, 4);
		exec_instr("ovf setup", OP_LW, encode(OP_LW, 3'd1, 3'd0), 16'h7fff);
		exec_instr("aw ovf", OP_AW, encode(OP_AW, 3'd1, 3'd0), 16'h0001);
		exec_instr("sw zero", OP_SW, encode(OP_SW, 3'd1, 3'd1), 16'h0000);   // R1-R1
		exec_instr("ac carry", OP_AC, encode(OP_AC, 3'd1, 3'd0), 16'h0001);  // C set above
		random_alu(OP_AW, 6);
		random_alu(OP_AC, 6);
		random_alu(OP_SW, 6);
		random_alu(OP_OR, 3);
		random_alu(OP_NR, 3);
		random_alu(OP_ER, 3);
		random_alu(OP_XR, 3);
		random_alu(OP_CW, 4);
		jumps();
		exec_instr("illegal op", OP_ILL, {6'o77, 1'b0, 3'd4, 3'd0, 3'd1}, 16'h0000);
		exec_instr("illegal J", OP_ILL, {6'o74, 1'b0, 3'd3, 3'd0, 3'd0}, 16'h1234);
		exec_instr("after illegal", OP_AW, encode(OP_AW, 3'd4, 3'd1), 16'h0000);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== hw/mera_exec.sv ====
`timescale 1ns/1ps
// ****************************************
// Execution slice top: P-D, sequencer,
// ALU and register file
// ****************************************
module mera_exec import mera_isa_pkg::*, mera_ctl_pkg::*; #(
	parameter logic [0:WORD_W-1] IC_RESET = 16'h0100
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [0:WORD_W-1] w,          // Host word
	input  logic              w_stb,      // Single-cycle word strobe
	input  logic [0:FLD_W-1]  panel_sel,
	output logic              ekc,        // Instruction cycle end
	output logic              xi,         // Illegal, valid with ekc
	output logic              nef,        // Ineffective, valid with ekc
	output logic [0:WORD_W-1] ic,
	output logic [0:WORD_W-1] panel_data
);

	opcode_t           op;
	logic [0:FLD_W-1]  a_fld;
	logic [0:FLD_W-1]  c_fld;
	logic              c0;
	logic              ir_load;
	logic              arg_load;
	logic              ic_inc;
	logic              ic_load;
	logic              reg_we;
	logic              r0_we;
	alu_op_t           alu_op;
	logic [0:WORD_W-1] opa;
	logic [0:WORD_W-1] arg;
	logic [0:WORD_W-1] r0;
	logic [0:WORD_W-1] y;
	logic [0:FLAG_W-1] flags;

	p_d u_pd (
		.clk(clk), .rst_n(rst_n), .w(w), .ir_load(ir_load), .r0(r0),
		.op(op), .a_fld(a_fld), .c_fld(c_fld), .c0(c0), .xi(xi), .nef(nef)
	);

	cpu_ctl u_ctl (
		.clk(clk), .rst_n(rst_n), .w_stb(w_stb), .op(op), .c0(c0), .xi(xi), .nef(nef),
		.ir_load(ir_load), .arg_load(arg_load), .ic_inc(ic_inc), .ic_load(ic_load),
		.reg_we(reg_we), .r0_we(r0_we), .alu_op(alu_op), .ekc(ekc)
	);

	alu_flags u_alu (
		.a(opa), .b(arg), .cin(r0[R0_C]), .vin(r0[R0_V]), .alu_op(alu_op),
		.y(y), .flags(flags)
	);

	regfile #(.IC_RESET(IC_RESET)) u_rf (
		.clk(clk), .rst_n(rst_n), .w(w), .arg_load(arg_load), .ic_inc(ic_inc),
		.ic_load(ic_load), .reg_we(reg_we), .r0_we(r0_we), .a_fld(a_fld),
		.c_fld(c_fld), .c0(c0), .y(y), .flags(flags), .panel_sel(panel_sel),
		.opa(opa), .arg(arg), .r0(r0), .ic(ic), .panel_data(panel_data)
	);

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
// ****************************************
// R0..R7, argument register, IC
// ****************************************
module regfile import mera_isa_pkg::*; #(
	parameter logic [0:WORD_W-1] IC_RESET = 16'h0100
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [0:WORD_W-1] w,
	input  logic              arg_load,
	input  logic              ic_inc,
	input  logic              ic_load,
	input  logic              reg_we,
	input  logic              r0_we,
	input  logic [0:FLD_W-1]  a_fld,
	input  logic [0:FLD_W-1]  c_fld,
	input  logic              c0,
	input  logic [0:WORD_W-1] y,
	input  logic [0:FLAG_W-1] flags,
	input  logic [0:FLD_W-1]  panel_sel,
	output logic [0:WORD_W-1] opa,      // R[A]
	output logic [0:WORD_W-1] arg,      // Next word or R[C]
	output logic [0:WORD_W-1] r0,
	output logic [0:WORD_W-1] ic,
	output logic [0:WORD_W-1] panel_data
);

	logic [0:WORD_W-1] r [0:7];
	logic [0:WORD_W-1] arg_q;           // Stored argument word
	logic              r0_by_reg;       // Result write hits R0

	assign r0_by_reg = reg_we && (a_fld == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				r[i] <= '0;
			end
		end else begin
			if (reg_we) begin
				r[a_fld] <= y;
			end
			if (r0_we && !r0_by_reg) begin
				r[0] <= {flags, {(WORD_W - FLAG_W){1'b0}}};   // Upper flags cleared
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ic <= IC_RESET;
		end else if (ic_load) begin
			ic <= arg;                          // Jump target
		end else if (ic_inc) begin
			ic <= ic + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (arg_load) begin
			arg_q <= w;
		end
	end

	assign arg = c0 ? arg_q : r[c_fld];
	assign opa = r[a_fld];
	assign r0 = r[0];
	assign panel_data = r[panel_sel];     // Front panel view

endmodule

// ==== hw/alu_flags.sv ====
`timescale 1ns/1ps
// ****************************************
// 16-bit ALU with Z, M, V, C flags
// ****************************************
module alu_flags import mera_isa_pkg::*, mera_ctl_pkg::*; (
	input  logic [0:WORD_W-1] a,        // R[A]
	input  logic [0:WORD_W-1] b,        // Argument
	input  logic              cin,      // Old C
	input  logic              vin,      // Old V
	input  alu_op_t           alu_op,
	output logic [0:WORD_W-1] y,
	output logic [0:FLAG_W-1] flags     // Laid out as R0 bits 0..3
);

	logic [0:WORD_W-1] bx;              // Adder B input
	logic              ci;              // Adder carry-in
	logic [0:WORD_W]   sum;             // Bit 0 is carry-out
	logic              arith;           // Adder result selected
	logic              v;
	logic              c;

	// Adder input setup
	always_comb begin
		bx = b;
		ci = 1'b0;
		arith = 1'b0;
		case (alu_op)
			ALU_ADD: arith = 1'b1;
			ALU_ADC: begin
				arith = 1'b1;
				ci = cin;                         // Chain previous carry
			end
			ALU_SUB: begin
				arith = 1'b1;
				bx = ~b;                          // a + ~b + 1
				ci = 1'b1;
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, a} + {1'b0, bx} + {{WORD_W{1'b0}}, ci};

	always_comb begin
		case (alu_op)
			ALU_PASS: y = b;
			ALU_ADD, ALU_ADC, ALU_SUB: y = sum[1:WORD_W];
			ALU_OR:   y = a | b;
			ALU_AND:  y = a & b;
			ALU_ANDN: y = a & ~b;               // Erase
			ALU_XOR:  y = a ^ b;
			default:  y = b;
		endcase
	end

	// Signed overflow, operands agree but result sign differs
	assign v = arith ? ((a[0] == bx[0]) && (y[0] != a[0])) : vin;
	assign c = arith ? sum[0] : cin;        // Logic ops keep C

	assign flags[R0_Z] = (y == '0);
	assign flags[R0_M] = y[0];              // Sign bit
	assign flags[R0_V] = v;
	assign flags[R0_C] = c;

endmodule

// ==== hw/cpu_ctl.sv ====
`timescale 1ns/1ps
// ****************************************
// Instruction cycle sequencer
// ALU op mapping, write enables, cycle end
// ****************************************
module cpu_ctl import mera_isa_pkg::*, mera_ctl_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    w_stb,      // Host word strobe
	input  opcode_t op,
	input  logic    c0,
	input  logic    xi,
	input  logic    nef,
	output logic    ir_load,    // W->IR
	output logic    arg_load,   // W->argument register
	output logic    ic_inc,     // IC+1 per accepted word
	output logic    ic_load,    // Effective jump
	output logic    reg_we,     // Result to R[A]
	output logic    r0_we,      // Flags to R0
	output alu_op_t alu_op,
	output logic    ekc         // Cycle end
);

	ctl_state_t state;
	ctl_state_t state_nxt;
	logic       exec;           // Legal instruction in ST_EXEC
	logic       op_wr_reg;      // Opcode writes R[A]
	logic       op_wr_flag;     // Opcode writes R0 flags
	logic       op_jmp;         // Jump group

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_FETCH;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_FETCH: if (w_stb) state_nxt = c0 ? ST_ARG : ST_EXEC;
			ST_ARG:   if (w_stb) state_nxt = ST_EXEC;   // No time limit
			ST_EXEC:  state_nxt = ST_END;
			ST_END:   state_nxt = ST_FETCH;
			default:  state_nxt = ST_FETCH;
		endcase
	end

	// Opcode to ALU function and destinations
	always_comb begin
		alu_op = ALU_PASS;
		op_wr_reg = 1'b1;
		op_wr_flag = 1'b1;
		op_jmp = 1'b0;
		case (op)
			OP_LW: op_wr_flag = 1'b0;               // Flags untouched
			OP_AW: alu_op = ALU_ADD;
			OP_AC: alu_op = ALU_ADC;
			OP_SW: alu_op = ALU_SUB;
			OP_CW: begin
				alu_op = ALU_SUB;                     // Compare, flags only
				op_wr_reg = 1'b0;
			end
			OP_OR: alu_op = ALU_OR;
			OP_NR: alu_op = ALU_AND;
			OP_ER: alu_op = ALU_ANDN;
			OP_XR: alu_op = ALU_XOR;
			OP_UJ, OP_JZ, OP_JM, OP_JN: begin
				op_wr_reg = 1'b0;
				op_wr_flag = 1'b0;
				op_jmp = 1'b1;
			end
			default: begin
				op_wr_reg = 1'b0;
				op_wr_flag = 1'b0;
			end
		endcase
	end

	assign exec = (state == ST_EXEC) && !xi;    // Illegal writes nothing
	assign reg_we = exec && op_wr_reg;
	assign r0_we = exec && op_wr_flag;
	assign ic_load = exec && op_jmp && !nef;
	assign ir_load = (state == ST_FETCH) && w_stb;
	assign arg_load = (state == ST_ARG) && w_stb;
	assign ic_inc = ir_load || arg_load;
	assign ekc = (state == ST_END);

	// Host must hold off while an instruction executes
	a_no_stb_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(state inside {ST_EXEC, ST_END}) |-> !w_stb)
		else $error("cpu_ctl: word strobe during execution");

endmodule

// ==== hw/p_d.sv ====
`timescale 1ns/1ps
// ****************************************
// P-D unit: IR, opcode and field decode
// Illegal and ineffective instruction flags
// ****************************************
module p_d import mera_isa_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [0:WORD_W-1] w,        // Word bus from host
	input  logic              ir_load,  // W->IR
	input  logic [0:WORD_W-1] r0,       // Flags for jump conditions
	output opcode_t           op,       // Decoded instruction
	output logic [0:FLD_W-1]  a_fld,    // Register A
	output logic [0:FLD_W-1]  c_fld,    // Register C
	output logic              c0,       // C=0, argument in next word
	output logic              xi,       // Illegal
	output logic              nef       // Ineffective
);

	logic [0:WORD_W-1] ir;              // Instruction register
	logic              ir_vld;          // IR holds a fetched word
	logic [0:OPC_W-1]  opc;             // Raw opcode field
	logic              jmp_fail;        // Jump condition not met

	always_ff @(posedge clk) begin
		if (ir_load) begin
			ir <= w;                        // Instruction word from host
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir_vld <= 1'b0;
		end else if (ir_load) begin
			ir_vld <= 1'b1;
		end
	end

	assign opc = ir[0:OPC_W-1];         // ir[0:5]
	assign a_fld = ir[7:9];
	assign c_fld = ir[13:15];

	// During the load cycle the sequencer needs C of the incoming word
	assign c0 = ir_load ? (w[13:15] == '0) : (c_fld == '0);

	// Opcode decoder tree, group J split further on A
	always_comb begin
		op = OP_ILL;
		case (opc)
			OPC_LW: op = OP_LW;
			OPC_AW: op = OP_AW;
			OPC_AC: op = OP_AC;
			OPC_SW: op = OP_SW;
			OPC_CW: op = OP_CW;
			OPC_OR: op = OP_OR;
			OPC_NR: op = OP_NR;
			OPC_ER: op = OP_ER;
			OPC_XR: op = OP_XR;
			OPC_J: begin
				case (a_fld)
					JA_UJ:   op = OP_UJ;
					JA_JZ:   op = OP_JZ;        // Jump if Z
					JA_JM:   op = OP_JM;        // Jump if M
					JA_JN:   op = OP_JN;        // Jump if not Z
					default: op = OP_ILL;       // Other J variants dropped
				endcase
			end
			default: op = OP_ILL;
		endcase
	end

	// Conditional jumps with failed condition
	assign jmp_fail = ((op == OP_JZ) && !r0[R0_Z]) ||
		((op == OP_JM) && !r0[R0_M]) ||
		((op == OP_JN) && r0[R0_Z]);

	assign xi = ir_vld && (op == OP_ILL);  // Low until first fetch
	assign nef = ir_vld && jmp_fail;       // Illegal never ineffective

	// Opcode and A field must be defined once IR has been written
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		ir_load |=> !$isunknown({opc, a_fld}))
		else $error("p_d: opcode unknown after IR load");

endmodule

// ==== hw/mera_ctl_pkg.sv ====
// ****************************************
// Control types: sequencer states, ALU ops
// ****************************************
package mera_ctl_pkg;

	// Instruction cycle sequencer
	typedef enum logic [1:0] {
		ST_FETCH,           // Wait for instruction word
		ST_ARG,             // Wait for argument word (C=0)
		ST_EXEC,            // ALU result written at edge
		ST_END              // Cycle end, ekc high
	} ctl_state_t;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_PASS,           // y = b
		ALU_ADD,            // a + b
		ALU_ADC,            // a + b + C
		ALU_SUB,            // a + ~b + 1
		ALU_OR,
		ALU_AND,
		ALU_ANDN,           // a & ~b
		ALU_XOR
	} alu_op_t;

endpackage

// ==== hw/mera_isa_pkg.sv ====
// ****************************************
// Instruction encoding: field widths, opcodes
// R0 flag positions, J group A values
// ****************************************
package mera_isa_pkg;

	localparam int WORD_W = 16;           // Machine word, bit 0 is MSB
	localparam int OPC_W = 6;             // Opcode field ir[0:5]
	localparam int FLD_W = 3;             // A, B, C register fields
	localparam int FLAG_W = 4;            // Z, M, V, C

	// R0 flag bit positions
	localparam int R0_Z = 0;              // Zero
	localparam int R0_M = 1;              // Minus
	localparam int R0_V = 2;              // Overflow
	localparam int R0_C = 3;              // Carry

	// Decoded instruction
	typedef enum logic [3:0] {
		OP_LW, OP_AW, OP_AC, OP_SW, OP_CW,
		OP_OR, OP_NR, OP_ER, OP_XR,
		OP_UJ, OP_JZ, OP_JM, OP_JN,
		OP_ILL
	} opcode_t;

	// Octal opcode field values
	localparam logic [0:OPC_W-1] OPC_LW = 6'o20;
	localparam logic [0:OPC_W-1] OPC_AW = 6'o40;
	localparam logic [0:OPC_W-1] OPC_AC = 6'o41;
	localparam logic [0:OPC_W-1] OPC_SW = 6'o42;
	localparam logic [0:OPC_W-1] OPC_CW = 6'o43;
	localparam logic [0:OPC_W-1] OPC_OR = 6'o44;
	localparam logic [0:OPC_W-1] OPC_NR = 6'o46;
	localparam logic [0:OPC_W-1] OPC_ER = 6'o50;
	localparam logic [0:OPC_W-1] OPC_XR = 6'o52;
	localparam logic [0:OPC_W-1] OPC_J = 6'o74;   // Jump group, A selects

	// A field under group J
	localparam logic [0:FLD_W-1] JA_UJ = 3'd2;
	localparam logic [0:FLD_W-1] JA_JZ = 3'd4;
	localparam logic [0:FLD_W-1] JA_JM = 3'd5;
	localparam logic [0:FLD_W-1] JA_JN = 3'd6;

endpackage
